// ==== glm_defs.svh ====
`ifndef GLM_DEFS_SVH
`define GLM_DEFS_SVH

// Lanes of 32 bits in one model or sample line
`define GLM_LANES 4

// Model memory line address width
`define GLM_ADDR_W 8

// Q16.16 fraction bits
`define GLM_FRAC_W 16

// Depth of the sample, gradient and product FIFOs
`define GLM_FIFO_DEPTH 4

`endif

// ==== glm_pkg.sv ====
`default_nettype none

`include "glm_defs.svh"

package glm_pkg;

    // One signed Q16.16 value
    typedef logic signed [31:0] word_t;

    // Full line, lane 0 in the low bits
    typedef word_t [`GLM_LANES-1:0] line_t;

    typedef logic [`GLM_ADDR_W-1:0] addr_t;   // Model line address

    typedef logic [15:0] count_t;   // Line and iteration counts

endpackage

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "glm_defs.svh"

module sync_fifo
#(
    parameter type payload_t = glm_pkg::line_t
)
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic in_valid,
    output logic      in_ready,
    input  wire payload_t in_data,
    output logic      out_valid,
    input  wire logic out_ready,
    output payload_t  out_data,
    output logic [$clog2(`GLM_FIFO_DEPTH+1)-1:0] count
);
    localparam int DEPTH = `GLM_FIFO_DEPTH;
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic push;
    logic pop;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != 0);
    assign out_data  = mem[rd_ptr];   // First word falls through
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

// ==== scalar_vector_mult.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "glm_defs.svh"

module scalar_vector_mult
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic in_valid,
    input  wire glm_pkg::word_t scalar,
    input  wire glm_pkg::line_t vector,
    output logic out_valid,
    output glm_pkg::line_t result
);
    logic signed [63:0] prod [`GLM_LANES];   // Full width lane products
    logic valid1;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid1    <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            valid1    <= in_valid;
            out_valid <= valid1;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `GLM_LANES; i++)
        begin
            prod[i] <= $signed(scalar) * $signed(vector[i]);
            // Back to Q16.16, upper bits dropped
            result[i] <= glm_pkg::word_t'(prod[i] >>> `GLM_FRAC_W);
        end
    end

endmodule

`default_nettype wire

// ==== model_update.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "glm_defs.svh"

module model_update
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    output logic done,
    input  wire glm_pkg::addr_t model_offset,
    input  wire glm_pkg::count_t model_length,
    input  wire glm_pkg::count_t num_iterations,
    input  wire logic fwd_enable,
    input  wire logic sample_valid,
    output logic sample_ready,
    input  wire glm_pkg::line_t sample_data,
    input  wire logic grad_valid,
    output logic grad_ready,
    input  wire glm_pkg::word_t grad_data,
    output logic mult_valid,
    output glm_pkg::word_t mult_scalar,
    output glm_pkg::line_t mult_vector,
    input  wire logic prod_valid,
    output logic prod_ready,
    input  wire glm_pkg::line_t prod_data,
    input  wire logic [$clog2(`GLM_FIFO_DEPTH+1)-1:0] prod_count,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output glm_pkg::addr_t wb_adr,
    output glm_pkg::line_t wb_dat_w,
    input  wire glm_pkg::line_t wb_dat_r,
    input  wire logic wb_ack,
    output logic fwd_valid,
    input  wire logic fwd_ready,
    output glm_pkg::line_t fwd_data
);
    typedef enum logic [2:0]
    {
        S_IDLE,
        S_WAIT,    // Waiting for a product
        S_READ,
        S_SUB,
        S_WRITE
    } state_t;
    state_t state;

    glm_pkg::addr_t  offset_q;
    glm_pkg::count_t length_q;
    glm_pkg::count_t iters_q;
    logic            fwd_en_q;

    glm_pkg::count_t issue_line;
    glm_pkg::count_t issue_iter;
    glm_pkg::word_t  grad_q;    // Gradient of the iteration being issued
    logic [1:0]      issue_d;   // Lines inside the multiplier
    logic [$clog2(`GLM_FIFO_DEPTH+1)+1:0] pending;
    logic            issue_first;
    logic            issue_fire;

    glm_pkg::count_t wb_line;
    glm_pkg::count_t wb_iter;
    glm_pkg::line_t  prod_q;
    glm_pkg::line_t  model_q;
    glm_pkg::line_t  new_line;
    logic            wr_started;
    logic            wr_go;

    // Product FIFO slots already spoken for
    always_comb
    begin
        pending     = prod_count + issue_d[0] + issue_d[1];
        issue_first = (issue_line == '0);
        issue_fire  = (state != S_IDLE) && (issue_iter < iters_q) && sample_valid
                      && (grad_valid || !issue_first) && (pending < `GLM_FIFO_DEPTH);
    end

    assign sample_ready = issue_fire;
    assign grad_ready   = issue_fire && issue_first;
    assign mult_valid   = issue_fire;
    assign mult_scalar  = issue_first ? grad_data : grad_q;
    assign mult_vector  = sample_data;
    assign prod_ready   = (state == S_WAIT);

    // Write waits for the forward side when forwarding is on
    assign wr_go    = (state == S_WRITE) && (wr_started || !fwd_en_q || fwd_ready);
    assign wb_cyc   = (state == S_READ) || wr_go;
    assign wb_stb   = wb_cyc;
    assign wb_we    = (state == S_WRITE);
    assign wb_adr   = offset_q + glm_pkg::addr_t'(wb_line);
    assign wb_dat_w = new_line;

    assign fwd_valid = (state == S_WRITE) && fwd_en_q && !wr_started;
    assign fwd_data  = new_line;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= S_IDLE;
            done       <= 1'b0;
            wb_line    <= '0;
            wb_iter    <= '0;
            wr_started <= 1'b0;
            issue_line <= '0;
            issue_iter <= '0;
            issue_d    <= '0;
        end
        else
        begin
            done    <= 1'b0;
            issue_d <= {issue_d[0], issue_fire};
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        wb_line    <= '0;
                        wb_iter    <= '0;
                        issue_line <= '0;
                        issue_iter <= '0;
                        if (model_length == '0 || num_iterations == '0)
                            done <= 1'b1;   // Nothing to update
                        else
                            state <= S_WAIT;
                    end
                end
                S_WAIT:
                    if (prod_valid)
                        state <= S_READ;
                S_READ:
                    if (wb_ack)
                        state <= S_SUB;
                S_SUB:
                    state <= S_WRITE;
                S_WRITE:
                begin
                    if (wr_go)
                        wr_started <= 1'b1;
                    if (wb_ack)
                    begin
                        wr_started <= 1'b0;
                        state      <= S_WAIT;   // Bus idle for one cycle
                        if (wb_line == length_q - 1'b1)
                        begin
                            wb_line <= '0;
                            wb_iter <= wb_iter + 1'b1;
                            if (wb_iter == iters_q - 1'b1)
                            begin
                                done  <= 1'b1;
                                state <= S_IDLE;
                            end
                        end
                        else
                            wb_line <= wb_line + 1'b1;
                    end
                end
                default:
                    state <= S_IDLE;
            endcase

            if (issue_fire)
            begin
                if (issue_line == length_q - 1'b1)
                begin
                    issue_line <= '0;
                    issue_iter <= issue_iter + 1'b1;
                end
                else
                    issue_line <= issue_line + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && start)
        begin
            offset_q <= model_offset;
            length_q <= model_length;
            iters_q  <= num_iterations;
            fwd_en_q <= fwd_enable;
        end
        if (issue_fire && issue_first)
            grad_q <= grad_data;
        if (state == S_WAIT && prod_valid)
            prod_q <= prod_data;
        if (state == S_READ && wb_ack)
            model_q <= wb_dat_r;
        if (state == S_SUB)
        begin
            for (int i = 0; i < `GLM_LANES; i++)
                new_line[i] <= model_q[i] - prod_q[i];   // Wraps at 32 bits
        end
    end

endmodule

`default_nettype wire

// ==== model_bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module model_bus_arbiter
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic m0_cyc,
    input  wire logic m0_stb,
    input  wire logic m0_we,
    input  wire glm_pkg::addr_t m0_adr,
    input  wire glm_pkg::line_t m0_dat_w,
    output glm_pkg::line_t m0_dat_r,
    output logic m0_ack,
    input  wire logic m1_cyc,
    input  wire logic m1_stb,
    input  wire logic m1_we,
    input  wire glm_pkg::addr_t m1_adr,
    input  wire glm_pkg::line_t m1_dat_w,
    output glm_pkg::line_t m1_dat_r,
    output logic m1_ack,
    output logic s_cyc,
    output logic s_stb,
    output logic s_we,
    output glm_pkg::addr_t s_adr,
    output glm_pkg::line_t s_dat_w,
    input  wire glm_pkg::line_t s_dat_r,
    input  wire logic s_ack
);
    logic gnt_valid;
    logic gnt_sel;     // Low for model_update, high for the host
    logic owner_cyc;

    assign owner_cyc = gnt_sel ? m1_cyc : m0_cyc;

    // Re-arbitrate only once the owner has let go of cyc
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            gnt_valid <= 1'b0;
            gnt_sel   <= 1'b0;
        end
        else if (!gnt_valid || !owner_cyc)
        begin
            gnt_valid <= m0_cyc || m1_cyc;
            gnt_sel   <= !m0_cyc && m1_cyc;   // Master 0 wins a tie
        end
    end

    assign s_cyc   = gnt_valid && owner_cyc;
    assign s_stb   = gnt_valid && (gnt_sel ? m1_stb : m0_stb);
    assign s_we    = gnt_sel ? m1_we : m0_we;
    assign s_adr   = gnt_sel ? m1_adr : m0_adr;
    assign s_dat_w = gnt_sel ? m1_dat_w : m0_dat_w;

    assign m0_dat_r = s_dat_r;
    assign m1_dat_r = s_dat_r;
    assign m0_ack   = s_ack && gnt_valid && !gnt_sel;
    assign m1_ack   = s_ack && gnt_valid && gnt_sel;

endmodule

`default_nettype wire

// ==== model_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "glm_defs.svh"

module model_ram
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic cyc,
    input  wire logic stb,
    input  wire logic we,
    input  wire glm_pkg::addr_t adr,
    input  wire glm_pkg::line_t dat_w,
    output glm_pkg::line_t dat_r,
    output logic ack
);
    glm_pkg::line_t mem [2**`GLM_ADDR_W];
    logic access;

    // New request only while no ack is out
    assign access = cyc && stb && !ack;

    always_ff @(posedge clk)
    begin
        if (reset)
            ack <= 1'b0;
        else
            ack <= access;
    end

    always_ff @(posedge clk)
    begin
        if (access)
        begin
            if (we)
                mem[adr] <= dat_w;
            dat_r <= mem[adr];   // Valid alongside ack
        end
    end

endmodule

`default_nettype wire

// ==== glm_update_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "glm_defs.svh"

module glm_update_top
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    output logic done,
    input  wire glm_pkg::addr_t model_offset,
    input  wire glm_pkg::count_t model_length,
    input  wire glm_pkg::count_t num_iterations,
    input  wire logic fwd_enable,
    input  wire logic sample_valid,
    output logic sample_ready,
    input  wire glm_pkg::line_t sample_data,
    input  wire logic grad_valid,
    output logic grad_ready,
    input  wire glm_pkg::word_t grad_data,
    output logic fwd_valid,
    input  wire logic fwd_ready,
    output glm_pkg::line_t fwd_data,
    input  wire logic host_cyc,
    input  wire logic host_stb,
    input  wire logic host_we,
    input  wire glm_pkg::addr_t host_adr,
    input  wire glm_pkg::line_t host_dat_w,
    output glm_pkg::line_t host_dat_r,
    output logic host_ack
);
    logic           sq_valid;   // Sample FIFO head
    logic           sq_ready;
    glm_pkg::line_t sq_data;
    logic           gq_valid;   // Gradient FIFO head
    logic           gq_ready;
    glm_pkg::word_t gq_data;

    logic           mult_valid;
    glm_pkg::word_t mult_scalar;
    glm_pkg::line_t mult_vector;
    logic           mult_out_valid;
    glm_pkg::line_t mult_result;

    logic           prod_valid;
    logic           prod_ready;
    glm_pkg::line_t prod_data;
    logic [$clog2(`GLM_FIFO_DEPTH+1)-1:0] prod_count;

    logic           m0_cyc;
    logic           m0_stb;
    logic           m0_we;
    glm_pkg::addr_t m0_adr;
    glm_pkg::line_t m0_dat_w;
    glm_pkg::line_t m0_dat_r;
    logic           m0_ack;

    logic           s_cyc;
    logic           s_stb;
    logic           s_we;
    glm_pkg::addr_t s_adr;
    glm_pkg::line_t s_dat_w;
    glm_pkg::line_t s_dat_r;
    logic           s_ack;

    sync_fifo #(.payload_t(glm_pkg::line_t)) sample_fifo
    (
        .clk(clk),
        .reset(reset),
        .in_valid(sample_valid),
        .in_ready(sample_ready),
        .in_data(sample_data),
        .out_valid(sq_valid),
        .out_ready(sq_ready),
        .out_data(sq_data),
        .count()
    );

    sync_fifo #(.payload_t(glm_pkg::word_t)) grad_fifo
    (
        .clk(clk),
        .reset(reset),
        .in_valid(grad_valid),
        .in_ready(grad_ready),
        .in_data(grad_data),
        .out_valid(gq_valid),
        .out_ready(gq_ready),
        .out_data(gq_data),
        .count()
    );

    // Never full on a push, model_update reserves the slots
    sync_fifo #(.payload_t(glm_pkg::line_t)) prod_fifo
    (
        .clk(clk),
        .reset(reset),
        .in_valid(mult_out_valid),
        .in_ready(),
        .in_data(mult_result),
        .out_valid(prod_valid),
        .out_ready(prod_ready),
        .out_data(prod_data),
        .count(prod_count)
    );

    scalar_vector_mult mult
    (
        .clk(clk),
        .reset(reset),
        .in_valid(mult_valid),
        .scalar(mult_scalar),
        .vector(mult_vector),
        .out_valid(mult_out_valid),
        .result(mult_result)
    );

    model_update update
    (
        .clk(clk),
        .reset(reset),
        .start(start),
        .done(done),
        .model_offset(model_offset),
        .model_length(model_length),
        .num_iterations(num_iterations),
        .fwd_enable(fwd_enable),
        .sample_valid(sq_valid),
        .sample_ready(sq_ready),
        .sample_data(sq_data),
        .grad_valid(gq_valid),
        .grad_ready(gq_ready),
        .grad_data(gq_data),
        .mult_valid(mult_valid),
        .mult_scalar(mult_scalar),
        .mult_vector(mult_vector),
        .prod_valid(prod_valid),
        .prod_ready(prod_ready),
        .prod_data(prod_data),
        .prod_count(prod_count),
        .wb_cyc(m0_cyc),
        .wb_stb(m0_stb),
        .wb_we(m0_we),
        .wb_adr(m0_adr),
        .wb_dat_w(m0_dat_w),
        .wb_dat_r(m0_dat_r),
        .wb_ack(m0_ack),
        .fwd_valid(fwd_valid),
        .fwd_ready(fwd_ready),
        .fwd_data(fwd_data)
    );

    model_bus_arbiter arbiter
    (
        .clk(clk),
        .reset(reset),
        .m0_cyc(m0_cyc),
        .m0_stb(m0_stb),
        .m0_we(m0_we),
        .m0_adr(m0_adr),
        .m0_dat_w(m0_dat_w),
        .m0_dat_r(m0_dat_r),
        .m0_ack(m0_ack),
        .m1_cyc(host_cyc),
        .m1_stb(host_stb),
        .m1_we(host_we),
        .m1_adr(host_adr),
        .m1_dat_w(host_dat_w),
        .m1_dat_r(host_dat_r),
        .m1_ack(host_ack),
        .s_cyc(s_cyc),
        .s_stb(s_stb),
        .s_we(s_we),
        .s_adr(s_adr),
        .s_dat_w(s_dat_w),
        .s_dat_r(s_dat_r),
        .s_ack(s_ack)
    );

    model_ram ram
    (
        .clk(clk),
        .reset(reset),
        .cyc(s_cyc),
        .stb(s_stb),
        .we(s_we),
        .adr(s_adr),
        .dat_w(s_dat_w),
        .dat_r(s_dat_r),
        .ack(s_ack)
    );

endmodule

`default_nettype wire

// ==== glm_update_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module glm_update_sva
(
    input wire logic clk,
    input wire logic reset,
    input wire logic done,
    input wire logic m0_cyc,
    input wire logic m0_stb,
    input wire logic m0_ack,
    input wire logic m1_cyc,
    input wire logic m1_stb,
    input wire logic m1_ack,
    input wire logic s_cyc,
    input wire logic s_stb,
    input wire logic s_ack,
    input wire logic gnt_valid,
    input wire logic gnt_sel
);
    logic owner_cyc;

    assign owner_cyc = gnt_sel ? m1_cyc : m0_cyc;   // Cycle of the current owner

    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        s_ack |-> $past(s_cyc && s_stb))
        else $error("Slave ack without a request");

    m0_ack_after_req: assert property (@(posedge clk) disable iff (reset)
        m0_ack |-> $past(m0_cyc && m0_stb))
        else $error("Updater ack without a request");

    m1_ack_after_req: assert property (@(posedge clk) disable iff (reset)
        m1_ack |-> $past(m1_cyc && m1_stb))
        else $error("Host ack without a request");

    // Owner keeps the bus until it drops cyc
    grant_hold: assert property (@(posedge clk) disable iff (reset)
        (gnt_valid && owner_cyc) |=> (gnt_valid && gnt_sel == $past(gnt_sel)))
        else $error("Grant moved while cyc was high");

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        s_stb |-> s_cyc)
        else $error("Strobe without cycle");

    done_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !done)
        else $error("Done high during reset");

endmodule

bind glm_update_top glm_update_sva sva
(
    .clk(clk),
    .reset(reset),
    .done(done),
    .m0_cyc(m0_cyc),
    .m0_stb(m0_stb),
    .m0_ack(m0_ack),
    .m1_cyc(host_cyc),
    .m1_stb(host_stb),
    .m1_ack(host_ack),
    .s_cyc(s_cyc),
    .s_stb(s_stb),
    .s_ack(s_ack),
    .gnt_valid(arbiter.gnt_valid),
    .gnt_sel(arbiter.gnt_sel)
);

`default_nettype wire

// ==== tb_glm_update.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "glm_defs.svh"

module tb_glm_update;
    logic clk;
    logic reset;
    logic start;
    logic done;
    glm_pkg::addr_t model_offset;
    glm_pkg::count_t model_length;
    glm_pkg::count_t num_iterations;
    logic fwd_enable;
    logic sample_valid;
    logic sample_ready;
    glm_pkg::line_t sample_data;
    logic grad_valid;
    logic grad_ready;
    glm_pkg::word_t grad_data;
    logic fwd_valid;
    logic fwd_ready = 1'b1;
    glm_pkg::line_t fwd_data;
    logic host_cyc;
    logic host_stb;
    logic host_we;
    glm_pkg::addr_t host_adr;
    glm_pkg::line_t host_dat_w;
    glm_pkg::line_t host_dat_r;
    logic host_ack;

    glm_pkg::addr_t  cfg_offset;
    glm_pkg::count_t cfg_length;
    glm_pkg::count_t cfg_iters;
    glm_pkg::word_t  grads[$];
    glm_pkg::line_t  init_lines[$];
    glm_pkg::line_t  samples[$];
    glm_pkg::line_t  fwd_exp[$];
    glm_pkg::line_t  final_exp[$];
    glm_pkg::line_t  fwd_got[$];   // Lines taken from the forward port

    int errors = 0;
    int checks = 0;
    int done_count = 0;
    int timeout_cycles = 0;
    bit fwd_seen = 0;
    bit random_ready = 0;
    bit loaded = 0;
    bit golden_ok = 0;

    glm_update_top uut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Monitor between edges where outputs are settled
    always @(negedge clk)
    begin
        if (done)
            done_count++;
        if (fwd_valid)
            fwd_seen = 1'b1;
        if (fwd_valid && fwd_ready)
            fwd_got.push_back(fwd_data);
    end

    always @(posedge clk)
        fwd_ready <= random_ready ? 1'($urandom % 2) : 1'b1;

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic read_golden();
        int fd;
        int n;
        logic [8*200-1:0] text;
        logic [8*16-1:0] tag;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        fd = $fopen("glm_update_golden.txt", "r");
        if (fd == 0)
            $display("Error: cannot open glm_update_golden.txt");
        else
        begin
            while (!$feof(fd))
            begin
                text = '0;
                n = $fgets(text, fd);
                tag = '0;
                if (n > 0)
                    n = $sscanf(text, "%s %h %h %h %h", tag, a, b, c, d);
                if (tag == "cfg")
                begin
                    cfg_offset = glm_pkg::addr_t'(a);
                    cfg_length = glm_pkg::count_t'(b);
                    cfg_iters  = glm_pkg::count_t'(c);
                end
                else if (tag == "grad")
                    grads.push_back(a);
                else if (tag == "init")
                    init_lines.push_back({d, c, b, a});   // Lane 0 in the low bits
                else if (tag == "sample")
                    samples.push_back({d, c, b, a});
                else if (tag == "fwd")
                    fwd_exp.push_back({d, c, b, a});
                else if (tag == "final")
                    final_exp.push_back({d, c, b, a});
            end
            $fclose(fd);
            golden_ok = (samples.size() == int'(cfg_length)) && (grads.size() == cfg_iters + 1)
                        && (init_lines.size() == int'(cfg_length));
            if (!golden_ok)
                $display("Error: golden file contents do not fit its configuration line");
        end
    endtask

    task automatic host_access(input bit write, input glm_pkg::addr_t adr,
                               input glm_pkg::line_t wdata, output glm_pkg::line_t rdata,
                               output int cycles);
        @(posedge clk);
        host_cyc   <= 1'b1;
        host_stb   <= 1'b1;
        host_we    <= write;
        host_adr   <= adr;
        host_dat_w <= wdata;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        while (!host_ack);
        rdata = host_dat_r;
        @(posedge clk);
        host_cyc <= 1'b0;
        host_stb <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic load_model();
        glm_pkg::line_t unused;
        int cycles;
        for (int k = 0; k < init_lines.size(); k++)
            host_access(1'b1, cfg_offset + glm_pkg::addr_t'(k), init_lines[k], unused, cycles);
    endtask

    task automatic check_model(input bit use_final);
        glm_pkg::line_t rd;
        int cycles;
        for (int k = 0; k < int'(cfg_length); k++)
        begin
            host_access(1'b0, cfg_offset + glm_pkg::addr_t'(k), '0, rd, cycles);
            check_value($sformatf("model line %0d", k), rd,
                        use_final ? final_exp[k] : fwd_exp[k]);
        end
    endtask

    task automatic check_forwarded();
        check_value("forward count", fwd_got.size(), fwd_exp.size());
        for (int k = 0; k < fwd_exp.size() && k < fwd_got.size(); k++)
            check_value($sformatf("forward line %0d", k), fwd_got[k], fwd_exp[k]);
    endtask

    task automatic push_samples(input int rounds);
        for (int r = 0; r < rounds; r++)
        begin
            for (int k = 0; k < samples.size(); k++)
            begin
                @(posedge clk);
                sample_valid <= 1'b1;
                sample_data  <= samples[k];
                @(negedge clk);
                while (!sample_ready)
                    @(negedge clk);
            end
        end
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    task automatic push_grads(input int first, input int count);
        for (int k = first; k < first + count; k++)
        begin
            @(posedge clk);
            grad_valid <= 1'b1;
            grad_data  <= grads[k];
            @(negedge clk);
            while (!grad_ready)
                @(negedge clk);
        end
        @(posedge clk);
        grad_valid <= 1'b0;
    endtask

    task automatic run_op(input int iters, input bit fwd_en, input int grad_first);
        int done_before;
        done_before = done_count;
        fwd_got.delete();
        fwd_seen = 1'b0;
        @(posedge clk);
        model_offset   <= cfg_offset;
        model_length   <= cfg_length;
        num_iterations <= glm_pkg::count_t'(iters);
        fwd_enable     <= fwd_en;
        start          <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        fork
            push_samples(iters);
            push_grads(grad_first, iters);
            do
                @(negedge clk);
            while (!done);
        join
        repeat (8) @(posedge clk);   // Room for a stray second pulse
        check_value("done pulses per start", done_count - done_before, 1);
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("Test %0d %s: %s", num, name, (errors == errors_before) ? "ok" : "errors");
    endtask

    task automatic run_tests();
        int e0;
        int cycles;
        glm_pkg::line_t rd;

        e0 = errors;
        for (int k = 0; k < init_lines.size(); k++)
        begin
            host_access(1'b1, 8'h40 + glm_pkg::addr_t'(k), init_lines[k], rd, cycles);
            check_value("host write ack delay", cycles, 2);
        end
        for (int k = 0; k < init_lines.size(); k++)
        begin
            host_access(1'b0, 8'h40 + glm_pkg::addr_t'(k), '0, rd, cycles);
            check_value("host read ack delay", cycles, 2);
            check_value($sformatf("host read line %0d", k), rd, init_lines[k]);
        end
        report_test(1, "host port", e0);

        e0 = errors;
        load_model();
        run_op(1, 1'b1, 0);
        check_forwarded();
        check_model(1'b0);
        report_test(2, "single iteration with forward", e0);

        e0 = errors;
        load_model();
        run_op(int'(cfg_iters), 1'b0, 1);
        check_value("forward valid seen", fwd_seen, 1'b0);
        check_model(1'b1);
        report_test(3, "several iterations", e0);

        e0 = errors;
        load_model();
        random_ready = 1'b1;
        run_op(1, 1'b1, 0);
        random_ready = 1'b0;
        check_forwarded();
        check_model(1'b0);
        report_test(4, "forward back-pressure", e0);

        e0 = errors;
        load_model();
        fork
            run_op(1, 1'b0, 0);
            begin
                repeat (4) @(posedge clk);
                for (int k = 0; k < init_lines.size(); k++)
                begin
                    host_access(1'b0, 8'h40 + glm_pkg::addr_t'(k), '0, rd, cycles);
                    check_value($sformatf("outside line %0d", k), rd, init_lines[k]);
                end
            end
        join
        check_model(1'b0);
        report_test(5, "host access during update", e0);
    endtask

    // Watchdog sized from the line count of all runs
    initial
    begin
        wait (loaded);
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        reset          = 1'b1;
        start          = 1'b0;
        model_offset   = '0;
        model_length   = '0;
        num_iterations = '0;
        fwd_enable     = 1'b0;
        sample_valid   = 1'b0;
        sample_data    = '0;
        grad_valid     = 1'b0;
        grad_data      = '0;
        host_cyc       = 1'b0;
        host_stb       = 1'b0;
        host_we        = 1'b0;
        host_adr       = '0;
        host_dat_w     = '0;
        void'($urandom(11329));
        read_golden();
        timeout_cycles = int'(cfg_length) * (3 + int'(cfg_iters)) * 20 + 3000;
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        if (golden_ok)
            run_tests();
        else
            errors++;
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== glm_update_golden.txt ====
# tags: cfg offset length iterations | init, sample, fwd, final lanes 0..3 in hex
# grad lines: first one for the single pass runs, the rest one per iteration of the long run
cfg 10 4 2
grad 00008000
grad 00010000
grad 00020000
init 00100000 00050000 00000000 00010000
init 00030000 00000000 ffff0000 00020000
init 00008000 00001000 00020000 ffff8000
init 7fff0000 00000000 00000000 00000000
sample 00020000 00010000 ffff0000 00008000
sample 00040000 fffe0000 00030000 00000000
sample 00010000 00010000 00010000 00010000
sample fffc0000 00020000 00100000 00018000
fwd 000f0000 00048000 00008000 0000c000
fwd 00010000 00010000 fffd8000 00020000
fwd 00000000 ffff9000 00018000 ffff0000
fwd 80010000 ffff0000 fff80000 ffff4000
final 000a0000 00020000 00030000 ffff8000
final fff70000 00060000 fff60000 00020000
final fffd8000 fffd1000 ffff0000 fffc8000
final 800b0000 fffa0000 ffd00000 fffb8000

// ==== glm_update_top.f ====
+incdir+.
glm_pkg.sv
sync_fifo.sv
scalar_vector_mult.sv
model_update.sv
model_bus_arbiter.sv
model_ram.sv
glm_update_top.sv
glm_update_sva.sv
tb_glm_update.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_glm_update
RTL_TOP   ?= glm_update_top
FILELIST  ?= glm_update_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
